// File: common/ioPkg.sv
package ioPkg;

  // bus word
  localparam int dataWidth = 32;
  typedef logic [dataWidth-1:0] word_t;

  // device address map, top of the address space
  localparam word_t hexAddr = 32'hFFFF_F000;
  localparam word_t ledrAddr = 32'hFFFF_F020;
  // key data, control register at +4
  localparam word_t keyAddr = 32'hFFFF_F080;
  // switch data, control register at +4
  localparam word_t swAddr = 32'hFFFF_F090;

  // status and control register bit positions
  localparam int readyBit = 0;
  localparam int overrunBit = 1;
  localparam int ieBit = 3;

  // board sizes
  localparam int numKeys = 4;
  localparam int numSwitches = 10;
  localparam int hexDigits = 6;
  localparam int segBits = 7;

  // shown on the display until software writes it
  localparam logic [4*hexDigits-1:0] hexResetValue = 24'h123456;

endpackage

// File: display/displayRegs.sv
`timescale 1ns/1ps

module displayRegs
  import ioPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   hexSel,
  input  logic                   ledSel,
  input  logic                   wrEn,
  input  word_t                  wrData,
  output word_t                  dispReadData,
  output logic [segBits-1:0]     hex0,
  output logic [segBits-1:0]     hex1,
  output logic [segBits-1:0]     hex2,
  output logic [segBits-1:0]     hex3,
  output logic [segBits-1:0]     hex4,
  output logic [segBits-1:0]     hex5,
  output logic [numSwitches-1:0] ledr
);

  localparam int hexBits = 4 * hexDigits;

  logic [hexBits-1:0] hexReg;
  logic [numSwitches-1:0] ledReg;
  logic [segBits-1:0] segs [hexDigits];

  // both registers update at the accepting edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hexReg <= hexResetValue;
      ledReg <= '0;
    end else begin
      if (hexSel && wrEn)
        hexReg <= wrData[hexBits-1:0];
      if (ledSel && wrEn)
        ledReg <= wrData[numSwitches-1:0];
    end
  end

  // zero-extended read-back
  assign dispReadData = hexSel ? word_t'(hexReg) : ledSel ? word_t'(ledReg) : '0;

  // one decoder per nibble, digit 0 is the low nibble
  for (genvar i = 0; i < hexDigits; i++) begin : gDigit
    sevenSegDecoder decoder (
      .digit(hexReg[4*i +: 4]),
      .seg(segs[i])
    );
  end

  assign hex0 = segs[0];
  assign hex1 = segs[1];
  assign hex2 = segs[2];
  assign hex3 = segs[3];
  assign hex4 = segs[4];
  assign hex5 = segs[5];
  assign ledr = ledReg;

endmodule

// File: display/sevenSegDecoder.sv
`timescale 1ns/1ps

module sevenSegDecoder
  import ioPkg::*;
(
  input  logic [3:0]         digit,
  output logic [segBits-1:0] seg
);

  // active low, bit 6 is g and bit 0 is a
  always_comb begin
    case (digit)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      // letters, b and d lower case
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
  end

endmodule

// File: dv/ioTopTb.sv
`timescale 1ns/1ps

module ioTopTb
  import ioPkg::*;
;

  localparam int memAddrBits = 16;
  localparam int memOps = 8;
  localparam int respTimeout = 20;
  localparam int pollLimit = 40;
  // byte addresses inside data memory, word aligned
  localparam word_t memAddrMask = word_t'((64'd1 << memAddrBits) - 64'd4);
  localparam word_t keyCtrl = keyAddr + 32'd4;
  localparam word_t swCtrl = swAddr + 32'd4;

  typedef enum logic [2:0] {
    opWrite,
    opRead,
    opKeys,
    opSwitches,
    opHold,
    opDrain,
    opPoll
  } op_t;

  // one stimulus row, exp only used by reads
  typedef struct packed {
    op_t   op;
    word_t addr;
    word_t data;
    word_t exp;
  } row_t;

  logic clk;
  logic reset;
  logic busValid;
  logic busWrite;
  word_t busAddr;
  word_t busWriteData;
  word_t busReadData;
  logic busReadValid;
  logic [numKeys-1:0] keyN;
  logic [numSwitches-1:0] sw;
  logic [segBits-1:0] hexOut [hexDigits];
  logic [numSwitches-1:0] ledr;

  // standard active-low glyphs, a in bit 0
  logic [segBits-1:0] glyphs [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  row_t rows[$];
  // reads in flight, oldest first
  word_t expAddr[$];
  word_t expData[$];
  bit expCheck[$];
  // clock count at which each response is due
  int expDue[$];
  int cycleCount = 0;
  word_t lastRead;
  word_t memModel [word_t];
  logic [4*hexDigits-1:0] hexModel;
  logic [numSwitches-1:0] ledrModel;
  word_t lcgState = 32'h7a6e_a86d;
  int errorCount = 0;
  int timeoutCount = 0;

  ioTop #(
    .memAddrBits(memAddrBits),
    .debounceCycles(8)
  ) DUT (
    .clk(clk),
    .reset(reset),
    .busValid(busValid),
    .busWrite(busWrite),
    .busAddr(busAddr),
    .busWriteData(busWriteData),
    .busReadData(busReadData),
    .busReadValid(busReadValid),
    .keyN(keyN),
    .sw(sw),
    .hex0(hexOut[0]),
    .hex1(hexOut[1]),
    .hex2(hexOut[2]),
    .hex3(hexOut[3]),
    .hex4(hexOut[4]),
    .hex5(hexOut[5]),
    .ledr(ledr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // rising edges seen so far
  always @(posedge clk) cycleCount <= cycleCount + 1;

  function automatic word_t lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic void addRow(op_t op, word_t addr, word_t data, word_t exp);
    row_t r;
    r.op = op;
    r.addr = addr;
    r.data = data;
    r.exp = exp;
    rows.push_back(r);
  endfunction

  task automatic checkValue(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  // segments and leds against the register models
  task automatic checkDisplay();
    for (int i = 0; i < hexDigits; i++)
      checkValue($sformatf("hex%0d", i), word_t'(glyphs[hexModel[4*i +: 4]]),
        word_t'(hexOut[i]));
    checkValue("ledr", word_t'(ledrModel), word_t'(ledr));
  endtask

  // one bus cycle, response checked by the monitor
  task automatic issueRead(input word_t addr, input word_t exp, input bit check);
    busValid = 1'b1;
    busWrite = 1'b0;
    busAddr = addr;
    busWriteData = '0;
    expAddr.push_back(addr);
    expData.push_back(exp);
    expCheck.push_back(check);
    // accepted at the next edge, valid after the one after
    expDue.push_back(cycleCount + 2);
    @(negedge clk);
    busValid = 1'b0;
  endtask

  // write takes effect at the accepting edge, displays checked right after
  task automatic issueWrite(input word_t addr, input word_t data);
    busValid = 1'b1;
    busWrite = 1'b1;
    busAddr = addr;
    busWriteData = data;
    @(negedge clk);
    busValid = 1'b0;
    busWrite = 1'b0;
    if (addr == hexAddr)
      hexModel = data[4*hexDigits-1:0];
    if (addr == ledrAddr)
      ledrModel = data[numSwitches-1:0];
    checkDisplay();
  endtask

  task automatic waitResponses();
    int cycles;
    cycles = 0;
    while (expData.size() != 0 && cycles < respTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (expData.size() != 0) begin
      $display("TIMEOUT at %0t: %0d reads got no busReadValid", $time, expData.size());
      timeoutCount++;
    end
  endtask

  // read a status register until all mask bits are set
  task automatic pollStatus(input word_t addr, input word_t mask);
    int tries;
    bit done;
    tries = 0;
    done = 1'b0;
    while (!done && tries < pollLimit && timeoutCount == 0) begin
      issueRead(addr, '0, 1'b0);
      waitResponses();
      done = (lastRead & mask) == mask;
      tries++;
    end
    if (!done && timeoutCount == 0) begin
      $display("TIMEOUT at %0t: status at %h never showed bits %h", $time, addr, mask);
      timeoutCount++;
    end
  endtask

  task automatic applyRow(input row_t row);
    case (row.op)
      opWrite: issueWrite(row.addr, row.data);
      opRead: issueRead(row.addr, row.exp, 1'b1);
      opKeys: begin
        // data holds the pressed pattern
        keyN = ~row.data[numKeys-1:0];
        @(negedge clk);
      end
      opSwitches: begin
        sw = row.data[numSwitches-1:0];
        @(negedge clk);
      end
      opHold: repeat (row.data) @(negedge clk);
      opDrain: waitResponses();
      default: pollStatus(row.addr, row.data);
    endcase
  endtask

  task automatic buildTable();
    word_t memAddrs [memOps];
    word_t addr;
    word_t data;
    // after reset, nothing outstanding and status clear
    addRow(opHold, '0, 4, '0);
    addRow(opRead, keyCtrl, '0, 32'h0);
    addRow(opRead, swCtrl, '0, 32'h0);
    addRow(opDrain, '0, '0, '0);
    // memory, random words at random places
    for (int i = 0; i < memOps; i++) begin
      addr = lcgNext() & memAddrMask;
      data = lcgNext();
      memAddrs[i] = addr;
      memModel[addr >> 2] = data;
      addRow(opWrite, addr, data, '0);
    end
    // all reads back to back
    for (int i = 0; i < memOps; i++)
      addRow(opRead, memAddrs[i], '0, memModel[memAddrs[i] >> 2]);
    addRow(opDrain, '0, '0, '0);
    // unmapped space reads zero
    addRow(opRead, 32'h8000_0000, '0, 32'h0);
    addRow(opRead, 32'hFFFF_F040, '0, 32'h0);
    addRow(opDrain, '0, '0, '0);
    // display, mixed with a memory read in the pipe
    addRow(opWrite, hexAddr, 32'hFFAB_CDEF, '0);
    addRow(opWrite, ledrAddr, 32'hFFFF_F3A5, '0);
    addRow(opRead, memAddrs[0], '0, memModel[memAddrs[0] >> 2]);
    addRow(opRead, hexAddr, '0, 32'h00AB_CDEF);
    addRow(opRead, ledrAddr, '0, 32'h0000_03A5);
    addRow(opDrain, '0, '0, '0);
    // key press, then data read clears ready
    addRow(opKeys, '0, 32'h5, '0);
    addRow(opHold, '0, 2, '0);
    addRow(opRead, keyCtrl, '0, 32'h1);
    addRow(opRead, keyAddr, '0, 32'h5);
    addRow(opRead, keyCtrl, '0, 32'h0);
    addRow(opDrain, '0, '0, '0);
    // two changes with no read in between
    addRow(opKeys, '0, 32'h1, '0);
    addRow(opKeys, '0, 32'h3, '0);
    addRow(opHold, '0, 2, '0);
    addRow(opRead, keyCtrl, '0, 32'h3);
    // overrun bit at 0 clears it, ie bit set
    addRow(opWrite, keyCtrl, 32'h8, '0);
    addRow(opRead, keyCtrl, '0, 32'h9);
    addRow(opRead, keyAddr, '0, 32'h3);
    addRow(opRead, keyCtrl, '0, 32'h8);
    addRow(opWrite, keyCtrl, 32'h0, '0);
    addRow(opRead, keyCtrl, '0, 32'h0);
    addRow(opDrain, '0, '0, '0);
    // short glitch, shorter than the debounce window
    addRow(opSwitches, '0, 32'h2A5, '0);
    addRow(opHold, '0, 4, '0);
    addRow(opSwitches, '0, 32'h0, '0);
    addRow(opHold, '0, 20, '0);
    // status first, a data read would clear ready
    addRow(opRead, swCtrl, '0, 32'h0);
    addRow(opRead, swAddr, '0, 32'h0);
    addRow(opDrain, '0, '0, '0);
    // held pattern gets through
    addRow(opSwitches, '0, 32'h2A5, '0);
    addRow(opPoll, swCtrl, 32'h1, '0);
    addRow(opRead, swAddr, '0, 32'h2A5);
    addRow(opRead, swCtrl, '0, 32'h0);
    addRow(opDrain, '0, '0, '0);
    // switch overrun
    addRow(opSwitches, '0, 32'h155, '0);
    addRow(opPoll, swCtrl, 32'h1, '0);
    addRow(opSwitches, '0, 32'h0F0, '0);
    addRow(opPoll, swCtrl, 32'h2, '0);
    addRow(opRead, swCtrl, '0, 32'h3);
    addRow(opRead, swAddr, '0, 32'h0F0);
    addRow(opRead, swCtrl, '0, 32'h2);
    addRow(opWrite, swCtrl, 32'h8, '0);
    addRow(opRead, swCtrl, '0, 32'h8);
    addRow(opWrite, swCtrl, 32'h0, '0);
    addRow(opRead, swCtrl, '0, 32'h0);
    addRow(opDrain, '0, '0, '0);
  endtask

  // responses arrive in issue order
  always @(negedge clk) begin : responseMonitor
    word_t wantAddr;
    word_t wantData;
    bit wantCheck;
    int wantDue;
    if (busReadValid === 1'b1) begin
      assert (expData.size() != 0) else begin
        $display("ERROR at %0t: busReadValid high with no read outstanding", $time);
        errorCount++;
      end
      if (expData.size() != 0) begin
        wantAddr = expAddr.pop_front();
        wantData = expData.pop_front();
        wantCheck = expCheck.pop_front();
        wantDue = expDue.pop_front();
        lastRead = busReadData;
        checkValue("busReadValid cycle", word_t'(wantDue), word_t'(cycleCount));
        if (wantCheck)
          checkValue($sformatf("busReadData @%h", wantAddr), wantData, busReadData);
      end
    end
  end

  initial begin
    reset = 1'b1;
    busValid = 1'b0;
    busWrite = 1'b0;
    busAddr = '0;
    busWriteData = '0;
    keyN = '1;
    sw = '0;
    hexModel = hexResetValue;
    ledrModel = '0;
    buildTable();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    // reset value on the display
    checkDisplay();
    for (int i = 0; i < rows.size(); i++) begin
      if (timeoutCount == 0)
        applyRow(rows[i]);
    end
    if (timeoutCount == 0)
      waitResponses();
    $display("errors: %0d failed checks, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: inputs/keyPort.sv
`timescale 1ns/1ps

module keyPort
  import ioPkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               keySel,
  input  logic               regIndex,
  input  logic               wrEn,
  input  word_t              wrData,
  input  logic [numKeys-1:0] keyN,
  output word_t              keyReadData
);

  logic [numKeys-1:0] keyNow;
  logic [numKeys-1:0] prevKeys;
  logic keysChanged;
  logic dataRead;
  logic ctrlWrite;
  logic ready;
  logic overrun;
  logic ie;
  word_t statusWord;

  // keys are active low on the board
  assign keyNow = ~keyN;
  assign keysChanged = keyNow != prevKeys;
  assign dataRead = keySel && !wrEn && !regIndex;
  assign ctrlWrite = keySel && wrEn && regIndex;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      // start from the current keys so reset raises nothing
      prevKeys <= keyNow;
      ready <= 1'b0;
      overrun <= 1'b0;
      ie <= 1'b0;
    end else begin
      if (ctrlWrite) begin
        // writing 0 to overrun clears it, 1 leaves it
        if (!wrData[overrunBit])
          overrun <= 1'b0;
        ie <= wrData[ieBit];
      end
      if (dataRead)
        ready <= 1'b0;
      // a change wins over a read in the same cycle
      if (keysChanged) begin
        prevKeys <= keyNow;
        if (ready)
          overrun <= 1'b1;
        ready <= 1'b1;
      end
    end
  end

  always_comb begin
    statusWord = '0;
    statusWord[readyBit] = ready;
    statusWord[overrunBit] = overrun;
    statusWord[ieBit] = ie;
  end

  assign keyReadData = regIndex ? statusWord : word_t'(keyNow);

  // overrun only follows a change that found ready already set
  overrunNeedsReady: assert property (@(posedge clk) disable iff (reset)
    $rose(overrun) |-> $past(ready));

endmodule

// File: inputs/switchPort.sv
`timescale 1ns/1ps

module switchPort
  import ioPkg::*;
#(
  parameter int debounceCycles = 600000
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   swSel,
  input  logic                   regIndex,
  input  logic                   wrEn,
  input  word_t                  wrData,
  input  logic [numSwitches-1:0] sw,
  output word_t                  swReadData
);

  localparam int cntBits = $clog2(debounceCycles + 1);

  typedef enum logic {
    stStable,
    stBouncing
  } debounceState_t;

  debounceState_t state;
  logic [cntBits-1:0] count;
  logic [numSwitches-1:0] candidate;
  logic [numSwitches-1:0] swData;
  logic [numSwitches-1:0] prevData;
  logic dataChanged;
  logic dataRead;
  logic ctrlWrite;
  logic ready;
  logic overrun;
  logic ie;
  word_t statusWord;

  // debounce, count how long the raw input sits on one new value
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= stStable;
      count <= '0;
      candidate <= sw;
      swData <= sw;
    end else begin
      case (state)
        stStable: begin
          count <= '0;
          if (sw != swData) begin
            state <= stBouncing;
            candidate <= sw;
            count <= cntBits'(1);
          end
        end
        default: begin
          if (sw != candidate) begin
            // raw input moved, start over
            if (sw == swData) begin
              state <= stStable;
              count <= '0;
            end else begin
              candidate <= sw;
              count <= cntBits'(1);
            end
          end else if (count == cntBits'(debounceCycles)) begin
            // held long enough
            swData <= candidate;
            state <= stStable;
            count <= '0;
          end else begin
            count <= count + 1'b1;
          end
        end
      endcase
    end
  end

  assign dataChanged = swData != prevData;
  assign dataRead = swSel && !wrEn && !regIndex;
  assign ctrlWrite = swSel && wrEn && regIndex;

  // status bits, same rules as the keys
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prevData <= sw;
      ready <= 1'b0;
      overrun <= 1'b0;
      ie <= 1'b0;
    end else begin
      if (ctrlWrite) begin
        if (!wrData[overrunBit])
          overrun <= 1'b0;
        ie <= wrData[ieBit];
      end
      if (dataRead)
        ready <= 1'b0;
      if (dataChanged) begin
        prevData <= swData;
        if (ready)
          overrun <= 1'b1;
        ready <= 1'b1;
      end
    end
  end

  always_comb begin
    statusWord = '0;
    statusWord[readyBit] = ready;
    statusWord[overrunBit] = overrun;
    statusWord[ieBit] = ie;
  end

  assign swReadData = regIndex ? statusWord : word_t'(swData);

  // wait counter stays inside its window
  countInRange: assert property (@(posedge clk) disable iff (reset)
    count <= cntBits'(debounceCycles));

endmodule

// File: ioSystem.f
common/ioPkg.sv
display/sevenSegDecoder.sv
display/displayRegs.sv
source/dataMemory.sv
source/busDecoder.sv
inputs/keyPort.sv
inputs/switchPort.sv
source/ioTop.sv
dv/ioTopTb.sv

// File: run.sh
#!/bin/sh
# build and run the ioTop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ioTopTb \
  -f ioSystem.f \
  -o ioTopSim

./obj_dir/ioTopSim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
exit 0

// File: source/busDecoder.sv
`timescale 1ns/1ps

module busDecoder
  import ioPkg::*;
#(
  parameter int memAddrBits = 16
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  busValid,
  input  logic  busWrite,
  input  word_t busAddr,
  input  word_t busWriteData,
  output word_t busReadData,
  output logic  busReadValid,
  output logic  memSel,
  output logic  hexSel,
  output logic  ledSel,
  output logic  keySel,
  output logic  swSel,
  output logic  regIndex,
  output logic  wrEn,
  output word_t wrData,
  input  word_t memReadData,
  input  word_t dispReadData,
  input  word_t keyReadData,
  input  word_t swReadData
);

  typedef enum logic [2:0] {
    tgtNone,
    tgtMem,
    tgtHex,
    tgtLed,
    tgtKey,
    tgtSw
  } target_t;

  target_t target;
  target_t rdTarget;
  logic rdPending;
  word_t devReadData;
  word_t devData;

  // memory owns everything with the upper bits clear
  always_comb begin
    if (busAddr[dataWidth-1:memAddrBits] == '0)
      target = tgtMem;
    else if (busAddr == hexAddr)
      target = tgtHex;
    else if (busAddr == ledrAddr)
      target = tgtLed;
    // data and control words of each input device
    else if (busAddr == keyAddr || busAddr == word_t'(keyAddr + 4))
      target = tgtKey;
    else if (busAddr == swAddr || busAddr == word_t'(swAddr + 4))
      target = tgtSw;
    else
      target = tgtNone;
  end

  assign memSel = busValid && (target == tgtMem);
  assign hexSel = busValid && (target == tgtHex);
  assign ledSel = busValid && (target == tgtLed);
  assign keySel = busValid && (target == tgtKey);
  assign swSel = busValid && (target == tgtSw);

  // address bit 2 picks data or control inside a device
  assign regIndex = busAddr[2];
  assign wrEn = busWrite;
  assign wrData = busWriteData;

  // device values are combinational, take them now
  always_comb begin
    case (target)
      tgtHex, tgtLed: devReadData = dispReadData;
      tgtKey: devReadData = keyReadData;
      tgtSw: devReadData = swReadData;
      // unmapped reads come back as zero
      default: devReadData = '0;
    endcase
  end

  // first stage remembers target, second stage returns data
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rdPending <= 1'b0;
      rdTarget <= tgtNone;
      busReadValid <= 1'b0;
    end else begin
      rdPending <= busValid && !busWrite;
      rdTarget <= target;
      busReadValid <= rdPending;
    end
  end

  // memory word shows up one cycle late, so pick it here
  always_ff @(posedge clk) begin
    devData <= devReadData;
    busReadData <= (rdTarget == tgtMem) ? memReadData : devData;
  end

  // one target per access across all devices
  strobeOneHot: assert property (@(posedge clk) disable iff (reset)
    $onehot0({memSel, hexSel, ledSel, keySel, swSel}));

endmodule

// File: source/dataMemory.sv
`timescale 1ns/1ps

module dataMemory
  import ioPkg::*;
#(
  parameter int memAddrBits = 16
) (
  input  logic  clk,
  input  logic  memSel,
  input  logic  wrEn,
  input  word_t addr,
  input  word_t wrData,
  output word_t memReadData
);

  localparam int memWords = 2 ** (memAddrBits - 2);

  word_t mem [memWords];
  logic [memAddrBits-3:0] wordIndex;

  // byte address to word index
  assign wordIndex = addr[memAddrBits-1:2];

  // whole-word writes, registered reads
  always_ff @(posedge clk) begin
    if (memSel && wrEn)
      mem[wordIndex] <= wrData;
    if (memSel && !wrEn)
      memReadData <= mem[wordIndex];
  end

endmodule

// File: source/ioTop.sv
`timescale 1ns/1ps

module ioTop
  import ioPkg::*;
#(
  parameter int memAddrBits = 16,
  parameter int debounceCycles = 600000
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   busValid,
  input  logic                   busWrite,
  input  word_t                  busAddr,
  input  word_t                  busWriteData,
  output word_t                  busReadData,
  output logic                   busReadValid,
  input  logic [numKeys-1:0]     keyN,
  input  logic [numSwitches-1:0] sw,
  output logic [segBits-1:0]     hex0,
  output logic [segBits-1:0]     hex1,
  output logic [segBits-1:0]     hex2,
  output logic [segBits-1:0]     hex3,
  output logic [segBits-1:0]     hex4,
  output logic [segBits-1:0]     hex5,
  output logic [numSwitches-1:0] ledr
);

  // per-target strobes from the decoder
  logic memSel;
  logic hexSel;
  logic ledSel;
  logic keySel;
  logic swSel;
  // shared write path
  logic regIndex;
  logic wrEn;
  word_t wrData;
  // read values back into the decoder
  word_t memReadData;
  word_t dispReadData;
  word_t keyReadData;
  word_t swReadData;

  busDecoder #(
    .memAddrBits(memAddrBits)
  ) decoder (
    .clk(clk),
    .reset(reset),
    .busValid(busValid),
    .busWrite(busWrite),
    .busAddr(busAddr),
    .busWriteData(busWriteData),
    .busReadData(busReadData),
    .busReadValid(busReadValid),
    .memSel(memSel),
    .hexSel(hexSel),
    .ledSel(ledSel),
    .keySel(keySel),
    .swSel(swSel),
    .regIndex(regIndex),
    .wrEn(wrEn),
    .wrData(wrData),
    .memReadData(memReadData),
    .dispReadData(dispReadData),
    .keyReadData(keyReadData),
    .swReadData(swReadData)
  );

  // memory takes the raw bus address for its word index
  dataMemory #(
    .memAddrBits(memAddrBits)
  ) memory (
    .clk(clk),
    .memSel(memSel),
    .wrEn(wrEn),
    .addr(busAddr),
    .wrData(wrData),
    .memReadData(memReadData)
  );

  displayRegs display (
    .clk(clk),
    .reset(reset),
    .hexSel(hexSel),
    .ledSel(ledSel),
    .wrEn(wrEn),
    .wrData(wrData),
    .dispReadData(dispReadData),
    .hex0(hex0),
    .hex1(hex1),
    .hex2(hex2),
    .hex3(hex3),
    .hex4(hex4),
    .hex5(hex5),
    .ledr(ledr)
  );

  keyPort keys (
    .clk(clk),
    .reset(reset),
    .keySel(keySel),
    .regIndex(regIndex),
    .wrEn(wrEn),
    .wrData(wrData),
    .keyN(keyN),
    .keyReadData(keyReadData)
  );

  switchPort #(
    .debounceCycles(debounceCycles)
  ) switches (
    .clk(clk),
    .reset(reset),
    .swSel(swSel),
    .regIndex(regIndex),
    .wrEn(wrEn),
    .wrData(wrData),
    .sw(sw),
    .swReadData(swReadData)
  );

endmodule
